//--- design/posit_format_pkg.sv
package posit_format_pkg;

    localparam int N = 16;
    localparam int ES = 1;
    localparam int TE_SIZE = 7;                    // Holds +-28 plus a carry.
    localparam int MANT_SIZE = 14;                 // Hidden bit and fraction.
    localparam int MAX_TE_DIFF = 16;
    localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF + 1;
    localparam int MANT_SUB_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF;
    localparam int MAXPOS_TE = 28;
    localparam int MINPOS_TE = -28;

    typedef logic [N-1:0] posit_t;
    typedef logic signed [TE_SIZE-1:0] te_t;       // Regime times 2 plus exponent.
    typedef logic [MANT_SIZE-1:0] mant_t;          // MSB is the hidden bit.
    typedef logic [MANT_ADD_RESULT_SIZE-1:0] mant_sum_t;

    // Not a Real is the sign bit alone.
    localparam posit_t NAR = {1'b1, {(N-1){1'b0}}};

endpackage

//--- design/posit_stream_pkg.sv
package posit_stream_pkg;

    typedef enum logic {
        OP_ADD,
        OP_SUB
    } add_op_t;

    typedef struct packed {
        posit_format_pkg::posit_t a;
        posit_format_pkg::posit_t b;
        add_op_t op;
    } add_req_t;

    typedef struct packed {
        logic sign;                                // Sign of the larger operand.
        logic opposite_sign;
        posit_format_pkg::te_t te1;                // te1 is never below te2.
        posit_format_pkg::te_t te2;
        posit_format_pkg::mant_t mant1;
        posit_format_pkg::mant_t mant2;
        logic res_zero;
        logic res_nar;
        logic pass_b;
        posit_format_pkg::posit_t pass_value;
    } unpacked_pair_t;

    typedef struct packed {
        posit_format_pkg::posit_t result;
    } add_res_t;

endpackage

//--- design/posit_decode.sv
module posit_decode (
    input  posit_format_pkg::posit_t p,
    output logic                     sign,
    output posit_format_pkg::te_t    te,
    output posit_format_pkg::mant_t  mant,
    output logic                     is_zero,
    output logic                     is_nar
);

    import posit_format_pkg::*;

    function automatic logic [4:0] lead_zeros(input logic [N-2:0] v);
        logic [4:0] cnt;
        logic hit;
        cnt = '0;
        hit = 1'b0;
        for (int i = N - 2; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                cnt = cnt + 5'd1;
            end
        end
        return cnt;
    endfunction

    posit_t abs_p;
    logic [N-2:0] body;
    logic [N-2:0] rest;
    logic r0;
    logic [4:0] run_len;
    logic [ES-1:0] exp_bits;
    te_t regime;

    assign sign = p[N-1];
    assign is_zero = (p == '0);
    assign is_nar = (p == NAR);

    assign abs_p = sign ? -p : p;
    assign body = abs_p[N-2:0];
    assign r0 = body[N-2];                         // Value of the regime run.
    assign run_len = r0 ? lead_zeros(~body) : lead_zeros(body);
    assign rest = body << (run_len + 5'd1);        // Drop run and terminator.

    assign exp_bits = rest[N-2 -: ES];
    assign regime = r0 ? te_t'(run_len) - te_t'(1) : -te_t'(run_len);
    assign te = (regime <<< ES) + te_t'(exp_bits);
    assign mant = {1'b1, rest[N-2-ES -: MANT_SIZE-1]};

endmodule

//--- design/core_add.sv
module core_add (
    input  posit_format_pkg::mant_sum_t mant,
    input  posit_format_pkg::te_t       te_diff,
    output posit_format_pkg::mant_sum_t new_mant,
    output posit_format_pkg::te_t       new_te_diff,
    output logic                        frac_lsb_cut_off
);

    import posit_format_pkg::*;

    logic carry;

    assign carry = mant[MANT_ADD_RESULT_SIZE-1];   // Sum reached 2.0 or more.
    assign new_mant = carry ? mant >> 1 : mant;
    assign new_te_diff = carry ? te_diff + te_t'(1) : te_diff;
    assign frac_lsb_cut_off = carry & mant[0];

endmodule

//--- design/core_sub.sv
module core_sub (
    input  logic [posit_format_pkg::MANT_SUB_RESULT_SIZE-1:0] mant,
    input  posit_format_pkg::te_t                            te_diff,
    output posit_format_pkg::mant_sum_t                      new_mant,
    output posit_format_pkg::te_t                            new_te_diff
);

    import posit_format_pkg::*;

    function automatic logic [4:0] lead_zeros(input logic [MANT_SUB_RESULT_SIZE-1:0] v);
        logic [4:0] cnt;
        logic hit;
        cnt = '0;
        hit = 1'b0;
        for (int i = MANT_SUB_RESULT_SIZE - 1; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                cnt = cnt + 5'd1;
            end
        end
        return cnt;
    endfunction

    logic [4:0] shift;

    assign shift = lead_zeros(mant);
    // Cancellation only removes leading bits, so the shift is exact.
    assign new_mant = mant_sum_t'(mant << shift);
    assign new_te_diff = te_diff - te_t'(shift);

endmodule

//--- design/core_add_sub.sv
module core_add_sub (
    input  posit_format_pkg::te_t      te1_in,
    input  posit_format_pkg::te_t      te2_in,
    input  posit_format_pkg::mant_t    mant1_in,
    input  posit_format_pkg::mant_t    mant2_in,
    input  logic                       have_opposite_sign,
    output posit_format_pkg::mant_sum_t mant_out,
    output posit_format_pkg::te_t      te_out,
    output logic                       frac_lsb_cut_off
);

    import posit_format_pkg::*;

    function automatic mant_sum_t twos_comp(input mant_sum_t v);
        return ~v + mant_sum_t'(1);
    endfunction

    te_t te_diff;
    logic [MANT_SUB_RESULT_SIZE-1:0] mant1_up;
    logic [MANT_SUB_RESULT_SIZE-1:0] mant2_up;
    mant_sum_t mant_sum;
    mant_sum_t add_mant, sub_mant;
    te_t add_te_diff, sub_te_diff;
    logic add_cut;

    assign te_diff = te1_in - te2_in;              // Never negative after ordering.
    assign mant1_up = {mant1_in, {MAX_TE_DIFF{1'b0}}};
    assign mant2_up = (te_diff > te_t'(MAX_TE_DIFF)) ? '0
                    : {mant2_in, {MAX_TE_DIFF{1'b0}}} >> te_diff;

    assign mant_sum = mant_sum_t'(mant1_up) + (have_opposite_sign
                    ? twos_comp(mant_sum_t'(mant2_up)) : mant_sum_t'(mant2_up));

    core_add core_add_inst (
        .mant(mant_sum),
        .te_diff(te_diff),
        .new_mant(add_mant),
        .new_te_diff(add_te_diff),
        .frac_lsb_cut_off(add_cut)
    );

    core_sub core_sub_inst (
        .mant(mant_sum[MANT_SUB_RESULT_SIZE-1:0]),
        .te_diff(te_diff),
        .new_mant(sub_mant),
        .new_te_diff(sub_te_diff)
    );

    assign mant_out = have_opposite_sign ? sub_mant : add_mant;
    assign te_out = te2_in + (have_opposite_sign ? sub_te_diff : add_te_diff);
    assign frac_lsb_cut_off = have_opposite_sign ? 1'b0 : add_cut;

endmodule

//--- design/posit_encode.sv
module posit_encode (
    input  logic                        sign,
    input  posit_format_pkg::te_t       te,
    input  posit_format_pkg::mant_sum_t mant,
    input  logic                        sticky,
    output posit_format_pkg::posit_t    p
);

    import posit_format_pkg::*;

    localparam int BODY_W = N - 1;
    localparam int FRAC_W = MANT_ADD_RESULT_SIZE - 2;
    localparam int EXT_W = BODY_W + 1 + ES + FRAC_W;

    te_t te_c;
    te_t regime;
    logic r0;
    logic [4:0] run_len;
    logic [EXT_W-1:0] ext;
    logic [EXT_W-1:0] ext_sh;
    logic [BODY_W-1:0] body;
    logic [BODY_W-1:0] body_rnd;
    logic guard;
    logic round_bits;
    logic round_up;
    posit_t mag;

    assign te_c = (te > te_t'(MAXPOS_TE)) ? te_t'(MAXPOS_TE)
                : (te < te_t'(MINPOS_TE)) ? te_t'(MINPOS_TE) : te;

    assign regime = te_c >>> ES;
    assign r0 = ~regime[TE_SIZE-1];                // Ones run for a non-negative regime.
    assign run_len = r0 ? 5'(regime + te_t'(1)) : 5'(-regime);

    // Spare copies of the run bit are shifted out above the body.
    assign ext = {{BODY_W{r0}}, ~r0, te_c[ES-1:0], mant[FRAC_W-1:0]};
    assign ext_sh = ext << (5'(BODY_W) - run_len);

    assign body = ext_sh[EXT_W-1 -: BODY_W];
    assign guard = ext_sh[EXT_W-1-BODY_W];
    assign round_bits = (|ext_sh[EXT_W-2-BODY_W:0]) | sticky;
    assign round_up = guard & (round_bits | body[0]);

    // At maxpos the guard is the zero terminator, so no overflow.
    assign body_rnd = body + BODY_W'(round_up);
    assign mag = {1'b0, body_rnd};
    assign p = sign ? -mag : mag;

endmodule

//--- design/posit_unpack_stage.sv
module posit_unpack_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  posit_stream_pkg::add_req_t       req,
    output logic                             pair_valid,
    input  logic                             pair_ready,
    output posit_stream_pkg::unpacked_pair_t pair
);

    import posit_format_pkg::*;
    import posit_stream_pkg::*;

    logic sa, sb, za, zb, na, nb;
    te_t tea, teb;
    mant_t ma, mb;
    logic is_sub;
    logic sb_eff;
    logic a_first;
    logic same_mag;
    logic accept;
    unpacked_pair_t next_pair;

    posit_decode dec_a_inst (
        .p(req.a), .sign(sa), .te(tea), .mant(ma), .is_zero(za), .is_nar(na)
    );

    posit_decode dec_b_inst (
        .p(req.b), .sign(sb), .te(teb), .mant(mb), .is_zero(zb), .is_nar(nb)
    );

    assign is_sub = (req.op == OP_SUB);
    assign sb_eff = sb ^ is_sub;                   // Subtraction flips the sign of b.
    assign a_first = (tea > teb) || ((tea == teb) && (ma >= mb));
    assign same_mag = (tea == teb) && (ma == mb);

    always_comb begin
        next_pair.sign = a_first ? sa : sb_eff;
        next_pair.opposite_sign = sa ^ sb_eff;
        next_pair.te1 = a_first ? tea : teb;
        next_pair.te2 = a_first ? teb : tea;
        next_pair.mant1 = a_first ? ma : mb;
        next_pair.mant2 = a_first ? mb : ma;
        next_pair.res_nar = na | nb;
        next_pair.res_zero = (za & zb) | (~za & ~zb & same_mag & (sa ^ sb_eff));
        next_pair.pass_b = za ^ zb;
        next_pair.pass_value = za ? (is_sub ? -req.b : req.b) : req.a;
    end

    assign in_ready = !pair_valid || pair_ready;
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;
        end else if (accept) begin
            pair_valid <= 1'b1;
        end else if (pair_ready) begin
            pair_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pair <= next_pair;
        end
    end

endmodule

//--- design/posit_sum_stage.sv
module posit_sum_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pair_valid,
    output logic                             pair_ready,
    input  posit_stream_pkg::unpacked_pair_t pair,
    output logic                             out_valid,
    input  logic                             out_ready,
    output posit_stream_pkg::add_res_t       res
);

    import posit_format_pkg::*;

    mant_sum_t mant_sum;
    te_t te_sum;
    logic cut_off;
    posit_t enc_p;
    posit_t result;
    logic accept;

    core_add_sub core_add_sub_inst (
        .te1_in(pair.te1),
        .te2_in(pair.te2),
        .mant1_in(pair.mant1),
        .mant2_in(pair.mant2),
        .have_opposite_sign(pair.opposite_sign),
        .mant_out(mant_sum),
        .te_out(te_sum),
        .frac_lsb_cut_off(cut_off)
    );

    posit_encode posit_encode_inst (
        .sign(pair.sign), .te(te_sum), .mant(mant_sum), .sticky(cut_off), .p(enc_p)
    );

    always_comb begin
        if (pair.res_nar) begin
            result = NAR;
        end else if (pair.res_zero) begin
            result = '0;
        end else if (pair.pass_b) begin
            result = pair.pass_value;              // One operand was zero.
        end else begin
            result = enc_p;
        end
    end

    assign pair_ready = !out_valid || out_ready;
    assign accept = pair_valid && pair_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res.result <= result;
        end
    end

endmodule

//--- design/posit_adder_top.sv
module posit_adder_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  posit_stream_pkg::add_req_t req,
    output logic                       out_valid,
    input  logic                       out_ready,
    output posit_stream_pkg::add_res_t res
);

    import posit_stream_pkg::*;

    logic pair_valid;
    logic pair_ready;
    unpacked_pair_t pair;

    posit_unpack_stage posit_unpack_stage_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .req(req),
        .pair_valid(pair_valid),
        .pair_ready(pair_ready),
        .pair(pair)
    );

    posit_sum_stage posit_sum_stage_inst (
        .clk(clk),
        .rst_n(rst_n),
        .pair_valid(pair_valid),
        .pair_ready(pair_ready),
        .pair(pair),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .res(res)
    );

endmodule

//--- verification/posit_adder_tb.sv
module posit_adder_tb;

    import posit_format_pkg::*;
    import posit_stream_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h9ac3_51d4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int RESET_CYCLES = 16;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    add_req_t req;
    logic out_valid;
    logic out_ready;
    add_res_t res;

    add_req_t req_q[$];
    posit_t exp_q[$];
    logic [31:0] lfsr;
    logic started;
    int reset_count;
    int cycle_count;
    int timeout_limit;
    int send_idx;
    int recv_idx;
    int checks;
    int value_errors;
    int other_errors;

    posit_adder_top posit_adder_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .req(req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .res(res)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    task automatic check_posit(input string name, input posit_t actual, input posit_t expected);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic add_case(input posit_t a, input posit_t b, input add_op_t op,
                            input posit_t expected);
        add_req_t r;
        r.a = a;
        r.b = b;
        r.op = op;
        req_q.push_back(r);
        exp_q.push_back(expected);
    endtask

    task automatic load_table();
        add_case(16'h4000, 16'h4000, OP_ADD, 16'h5000);   // 1 + 1 = 2.
        add_case(16'h4000, 16'h3000, OP_ADD, 16'h4800);   // 1 + 0.5 = 1.5.
        add_case(16'h4000, 16'h5000, OP_ADD, 16'h5800);
        add_case(16'h5000, 16'h5000, OP_ADD, 16'h6000);
        add_case(16'h3000, 16'h3000, OP_ADD, 16'h4000);
        add_case(16'hC000, 16'hC000, OP_ADD, 16'hB000);   // -1 + -1 = -2.
        add_case(16'h4000, 16'h4000, OP_SUB, 16'h0000);
        add_case(16'h5000, 16'h4000, OP_SUB, 16'h4000);
        add_case(16'h4000, 16'h5000, OP_SUB, 16'hC000);
        add_case(16'h4800, 16'h4000, OP_SUB, 16'h3000);   // Cancellation needs a left shift.
        add_case(16'h4000, 16'hC000, OP_SUB, 16'h5000);
        add_case(16'h5000, 16'hC000, OP_ADD, 16'h4000);
        add_case(16'h4000, 16'hB000, OP_ADD, 16'hC000);
        add_case(16'h4000, 16'hC000, OP_ADD, 16'h0000);
        add_case(16'h8000, 16'h4000, OP_ADD, 16'h8000);
        add_case(16'h4000, 16'h8000, OP_SUB, 16'h8000);
        add_case(16'h8000, 16'h0000, OP_ADD, 16'h8000);
        add_case(16'h5800, 16'h0000, OP_ADD, 16'h5800);
        add_case(16'h0000, 16'h0000, OP_ADD, 16'h0000);
        add_case(16'h0000, 16'h4800, OP_SUB, 16'hB800);
        add_case(16'h7FFF, 16'h7FFF, OP_ADD, 16'h7FFF);   // Saturates at maxpos.
        add_case(16'h0001, 16'h0001, OP_SUB, 16'h0000);
        add_case(16'h4000, 16'h00C0, OP_ADD, 16'h4000);   // Half an ulp ties to even.
        add_case(16'h4001, 16'h00C0, OP_ADD, 16'h4002);   // Tie from an odd LSB rounds up.
        add_case(16'h4000, 16'h00C1, OP_ADD, 16'h4001);
        add_case(16'h4000, 16'h0001, OP_ADD, 16'h4000);
    endtask

    always @(posedge clk) begin
        if (reset_count < RESET_CYCLES) begin
            reset_count <= reset_count + 1;
        end else begin
            rst_n <= 1'b1;
        end
    end

    // Collector first, then driver, so the LFSR is stepped in a fixed order.
    always @(posedge clk) begin : handshake
        int next_idx;
        logic gap;
        logic stall;
        if (rst_n && !started) begin
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_ready", in_ready, 1'b1);
            started <= 1'b1;
        end else if (started) begin
            cycle_count <= cycle_count + 1;
            if (out_valid && out_ready) begin
                if (recv_idx < exp_q.size()) begin
                    check_posit($sformatf("res.result[%0d]", recv_idx), res.result,
                                exp_q[recv_idx]);
                end else begin
                    other_errors++;
                    $display("An extra result %h came after all %0d expected results",
                             res.result, exp_q.size());
                end
                recv_idx <= recv_idx + 1;
            end
            next_idx = send_idx;
            if (in_valid && in_ready) begin
                next_idx = send_idx + 1;
            end
            if (!in_valid || in_ready) begin           // A stalled request is held as it is.
                take_bit(gap);
                if (next_idx < req_q.size() && !gap) begin
                    in_valid <= 1'b1;
                    req <= req_q[next_idx];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            send_idx <= next_idx;
            take_bit(stall);
            out_ready <= !stall;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        req = '0;
        out_ready = 1'b0;
        lfsr = LFSR_SEED;
        started = 1'b0;
        reset_count = 0;
        cycle_count = 0;
        send_idx = 0;
        recv_idx = 0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        load_table();
        timeout_limit = req_q.size() * 8 + 100;
        while (recv_idx < req_q.size() && cycle_count < timeout_limit) begin
            @(posedge clk);
        end
        if (recv_idx < req_q.size()) begin
            other_errors++;
            $display("Timeout: only %0d of %0d results arrived within %0d cycles",
                     recv_idx, req_q.size(), timeout_limit);
        end else begin
            repeat (10) @(posedge clk);                // Watch for stray results.
        end
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/posit_format_pkg.sv
design/posit_stream_pkg.sv
design/posit_decode.sv
design/core_add.sv
design/core_sub.sv
design/core_add_sub.sv
design/posit_encode.sv
design/posit_unpack_stage.sv
design/posit_sum_stage.sv
design/posit_adder_top.sv
verification/posit_adder_tb.sv

//--- Makefile
SIM := obj_dir/Vposit_adder_tb

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard design/*.sv verification/*.sv)
	verilator --binary --timing --top-module posit_adder_tb -f verilog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
